// ==== filelist.f ====
+incdir+include
design/cpu_pkg.sv
design/pipe_reg.sv
design/operand_decoder.sv
design/hazard_detection_unit.sv
design/slot_sequencer.sv
design/issue_front_end.sv
bench/issue_front_end_props.sv
bench/issue_front_end_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and looks for the pass line.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module issue_front_end_tb -f filelist.f \
  --Mdir obj_dir -o issue_front_end_sim

./obj_dir/issue_front_end_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== bench/issue_front_end_tb.sv ====
`timescale 1ns/1ns

`include "cpu_consts.svh"

module issue_front_end_tb;

  import cpu_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int PROG_LEN   = 64;

  logic        clk;
  logic        rst_n;
  logic [31:0] fetch_word0;
  logic [31:0] fetch_word1;
  pc_t         pc;
  logic        ex_valid;
  opcode_t     ex_opcode;
  reg_idx_t    ex_rs;
  reg_idx_t    ex_rt;
  reg_idx_t    ex_rd;
  mem_op_t     ex_mem_op;
  pipe_mask_t  stall;

  logic [31:0] prog [0:PROG_LEN-1];
  int          errors [1:6];
  int          events [1:6];
  int          checks;
  int          exp_idx;

  // model copy of the DUT registers.
  pc_t         m_pc;
  logic        m_if_valid;
  logic [31:0] m_w0;
  logic [31:0] m_w1;
  logic        m_first;
  logic        m_ex_valid;
  logic [31:0] m_ex_word;
  int          prev_kind;  // hazard seen at the last edge.

  issue_front_end dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_word0 (fetch_word0),
    .fetch_word1 (fetch_word1),
    .pc          (pc),
    .ex_valid    (ex_valid),
    .ex_opcode   (ex_opcode),
    .ex_rs       (ex_rs),
    .ex_rt       (ex_rt),
    .ex_rd       (ex_rd),
    .ex_mem_op   (ex_mem_op),
    .stall       (stall)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // three eighths loads and register numbers of 0..3 so hazards come often.
  function automatic logic [31:0] make_instr(input logic [31:0] r);
    logic [5:0] op;
    case (r[31:29])
      3'd0, 3'd1: op = `OP_CODE_LW;
      3'd2:       op = `OP_CODE_LA;
      3'd3:       op = {2'b00, r[28:25]};
      3'd4:       op = {2'b01, r[28:25]};
      3'd5:       op = r[28] ? `OP_CODE_SW : `OP_CODE_SA;
      3'd6:       op = r[28] ? `OP_CODE_NOP : `OP_CODE_JR;
      default:    op = {2'b11, r[28:25]};
    endcase
    return {op, 3'b000, r[24:23], 3'b000, r[22:21], 3'b000, r[20:19], r[10:0]};
  endfunction

  // words past the program read as nop.
  function automatic logic [31:0] fetch_at(input pc_t addr);
    if ((addr >> 2) < PROG_LEN) return prog[addr >> 2];
    return 32'h0;
  endfunction

  // {src rs rt rd, dst rs rt rd, mem_op} from the opcode table.
  function automatic logic [7:0] decode_op(input logic [5:0] op);
    logic [2:0] src;
    logic [2:0] dst;
    logic [1:0] mem;
    src = 3'b000;
    dst = 3'b000;
    mem = MEM_OP_NONE;
    if (op == `OP_CODE_JR) src = 3'b100;
    else if (op[5:4] == 2'b00 && op != `OP_CODE_NOP) {src, dst} = 6'b110_001;
    else if (op[5:4] == 2'b01) {src, dst} = 6'b100_010;
    else if (op == `OP_CODE_LW) {src, dst} = 6'b100_010;
    else if (op == `OP_CODE_SW) src = 3'b110;
    else if (op == `OP_CODE_LA) dst = 3'b010;
    else if (op == `OP_CODE_SA) src = 3'b010;
    if (op == `OP_CODE_LW || op == `OP_CODE_LA) mem = MEM_OP_READ;
    if (op == `OP_CODE_SW || op == `OP_CODE_SA) mem = MEM_OP_WRITE;
    return {src, dst, mem};
  endfunction

  function automatic logic is_nop_or_jump(input logic [5:0] op);
    return op == `OP_CODE_NOP || op[5:4] == 2'b11;
  endfunction

  // 1 for load-use, 2 for a slot conflict, 0 when the slot may issue.
  function automatic int hazard_kind();
    logic [31:0] iw;
    logic [31:0] ow;
    logic [7:0]  di;
    logic [7:0]  dox;
    logic [7:0]  de;
    logic        rs_hit;
    logic        rt_hit;
    iw  = m_first ? m_w0 : m_w1;
    ow  = m_first ? m_w1 : m_w0;
    di  = decode_op(iw[31:26]);
    dox = decode_op(ow[31:26]);
    de  = decode_op(m_ex_word[31:26]);
    if (!m_if_valid || !m_ex_valid) return 0;  // an empty ex slot needs no bubble.
    if (de[1:0] == MEM_OP_READ &&
        ((di[7] && iw[25:21] == m_ex_word[20:16]) ||
         (di[6] && iw[20:16] == m_ex_word[20:16])))
      return 1;
    rs_hit = di[7] && ((dox[3] && iw[25:21] == ow[20:16]) ||
                       (dox[2] && iw[25:21] == ow[15:11]));
    rt_hit = di[6] && ((dox[3] && iw[20:16] == ow[20:16]) ||
                       (dox[2] && iw[20:16] == ow[15:11]));
    return (rs_hit || rt_hit) ? 2 : 0;
  endfunction

  task automatic flag_error(input int t, input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    errors[t]++;
    $display("** Error at %0t ns: test %0d %s, got %h, expected %h",
             $time, t, what, got, exp);
  endtask

  task automatic check_cycle(input int kind);
    logic [31:0] iw;
    logic [7:0]  de;
    int          t;
    iw = m_first ? m_w0 : m_w1;
    t  = (prev_kind == 0) ? 5 : prev_kind + 2;  // bubbles belong to tests 3 and 4.
    checks += 3;
    if (pc !== m_pc) flag_error(5, "pc", pc, m_pc);
    if (ex_valid !== m_ex_valid) flag_error(t, "ex_valid", ex_valid, m_ex_valid);
    if (stall !== {3{kind != 0}})
      flag_error(kind == 0 ? 5 : kind + 2, "stall", stall, {3{kind != 0}});
    if (kind != 0) events[kind + 2]++;
    // jr still waits on a load into rs.
    if (m_if_valid && is_nop_or_jump(iw[31:26]) && iw[31:26] != `OP_CODE_JR) begin
      events[6]++;
      checks++;
      if (stall !== '0) flag_error(6, "stall on nop or jump", stall, 32'h0);
    end
    if (ex_valid === 1'b1) begin
      de = decode_op(prog[exp_idx][31:26]);
      checks += 2;
      if ({ex_opcode, ex_rs, ex_rt, ex_rd} !== prog[exp_idx][31:11])
        flag_error(2, "ex fields", {ex_opcode, ex_rs, ex_rt, ex_rd}, prog[exp_idx][31:11]);
      if (ex_mem_op !== de[1:0])
        flag_error(is_nop_or_jump(ex_opcode) ? 6 : 2, "ex_mem_op", ex_mem_op, de[1:0]);
      events[2]++;
      if (prev_kind == 0) events[5]++;
      exp_idx++;
    end
  endtask

  task automatic step_model(input int kind);
    logic done;
    done = m_if_valid && kind == 0 && !m_first;
    if (kind != 0) begin
      m_ex_valid = 1'b0;  // bubble while the rest holds.
    end else begin
      m_ex_valid = m_if_valid;
      m_ex_word  = m_first ? m_w0 : m_w1;
      if (m_if_valid) m_first = !m_first;
    end
    if (kind == 0 && (done || !m_if_valid)) begin
      m_w0       = fetch_at(m_pc);
      m_w1       = fetch_at(m_pc + 4);
      m_if_valid = 1'b1;
      m_pc       = m_pc + 8;
    end
    prev_kind = kind;
  endtask

  task automatic report_test(input int t, input string name);
    $display("test %0d %s: %0d events, %0d errors", t, name, events[t], errors[t]);
  endtask

  initial begin
    #(PROG_LEN * 4 * CLK_PERIOD + 200);
    $display("timeout: the program did not drain out of the pipeline in time");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [31:0] seed;
    int          kind;
    int          total;
    clk         = 1'b0;
    rst_n       = 1'b0;
    fetch_word0 = '0;
    fetch_word1 = '0;
    checks      = 0;
    exp_idx     = 0;
    for (int i = 1; i <= 6; i++) begin
      errors[i] = 0;
      events[i] = 0;
    end
    seed = 32'h5514_c5d4;
    for (int i = 0; i < PROG_LEN; i++) begin
      seed    = lcg_next(seed);
      prog[i] = make_instr(seed);
    end
    repeat (2) begin
      @(negedge clk);
      events[1]++;
      checks += 2;
      if (pc !== '0) flag_error(1, "pc in reset", pc, 32'h0);
      if (ex_valid !== 1'b0) flag_error(1, "ex_valid in reset", ex_valid, 32'h0);
    end
    report_test(1, "reset");
    rst_n      = 1'b1;
    m_pc       = '0;
    m_if_valid = 1'b0;
    m_w0       = '0;
    m_w1       = '0;
    m_first    = 1'b1;
    m_ex_valid = 1'b0;
    m_ex_word  = '0;
    prev_kind  = 0;
    while (exp_idx < PROG_LEN) begin
      kind = hazard_kind();
      check_cycle(kind);
      fetch_word0 = fetch_at(pc);
      fetch_word1 = fetch_at(pc + 4);
      step_model(kind);
      @(negedge clk);
    end
    report_test(2, "program order");
    report_test(3, "load-use");
    report_test(4, "slot conflict");
    report_test(5, "independent issue");
    report_test(6, "nop and jump");
    total = dut.u_props.fails;
    for (int i = 1; i <= 6; i++) total += errors[i];
    $display("tests: 6, checks: %0d, assertion failures: %0d, errors: %0d",
             checks, dut.u_props.fails, total);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== bench/issue_front_end_props.sv ====
`timescale 1ns/1ns

`include "cpu_consts.svh"

module issue_front_end_props (
  input logic                clk,
  input logic                rst_n,
  input cpu_pkg::pipe_mask_t stall,
  input logic                nop_id_ex,
  input logic                ex_valid
);

  int fails = 0;  // failed assertion count.

  // hazard masks come from registered state only.
  stall_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(stall))
    else begin
      fails++;
      $error("stall mask is unknown");
    end

  // a bubble always shows up as an empty ex cycle.
  bubble_empties_ex: assert property (@(posedge clk) disable iff (!rst_n)
                                      nop_id_ex |=> !ex_valid)
    else begin
      fails++;
      $error("ex_valid high after an ID/EX bubble");
    end

endmodule

bind issue_front_end issue_front_end_props u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .stall     (stall),
  .nop_id_ex (nop[`PIPE_REG_ID_EX]),
  .ex_valid  (ex_valid)
);

// ==== design/issue_front_end.sv ====
`timescale 1ns/1ns

`include "cpu_consts.svh"

module issue_front_end (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`INSTR_BITS-1:0] fetch_word0,   // word at pc.
  input  logic [`INSTR_BITS-1:0] fetch_word1,   // word at pc + 4.
  output cpu_pkg::pc_t           pc,
  output logic                   ex_valid,
  output cpu_pkg::opcode_t       ex_opcode,
  output cpu_pkg::reg_idx_t      ex_rs,
  output cpu_pkg::reg_idx_t      ex_rt,
  output cpu_pkg::reg_idx_t      ex_rd,
  output cpu_pkg::mem_op_t       ex_mem_op,
  output cpu_pkg::pipe_mask_t    stall
);

  import cpu_pkg::*;

  pc_t         pc_next;
  logic        pc_hold;
  logic        if_id_hold;
  instr_pair_t fetch_pair;
  instr_pair_t if_id_pair;
  logic        if_id_valid;
  logic        first;
  issued_t     issue;
  logic        issue_valid;
  logic        pair_done;
  issued_t     ex_q;
  pipe_mask_t  nop;

  opcode_t     if_id_opcode0;
  opcode_t     if_id_opcode1;
  reg_idx_t    if_id_rs0;
  reg_idx_t    if_id_rt0;
  reg_idx_t    if_id_rd0;
  reg_idx_t    if_id_rs1;
  reg_idx_t    if_id_rt1;
  reg_idx_t    if_id_rd1;

  assign pc_next = pc + `PC_BITS'(`FETCH_STEP);

  assign fetch_pair.slot0 = fetch_word0;
  assign fetch_pair.slot1 = fetch_word1;

  // fetch moves only once the held pair has issued both slots.
  assign pc_hold    = stall[`PIPE_REG_PC] | (if_id_valid & ~pair_done);
  assign if_id_hold = stall[`PIPE_REG_IF_ID] | (if_id_valid & ~pair_done);

  assign if_id_opcode0 = if_id_pair.slot0[`OPCODE_HI:`OPCODE_LO];
  assign if_id_opcode1 = if_id_pair.slot1[`OPCODE_HI:`OPCODE_LO];
  assign if_id_rs0     = if_id_pair.slot0[`RS_HI:`RS_LO];
  assign if_id_rt0     = if_id_pair.slot0[`RT_HI:`RT_LO];
  assign if_id_rd0     = if_id_pair.slot0[`RD_HI:`RD_LO];
  assign if_id_rs1     = if_id_pair.slot1[`RS_HI:`RS_LO];
  assign if_id_rt1     = if_id_pair.slot1[`RT_HI:`RT_LO];
  assign if_id_rd1     = if_id_pair.slot1[`RD_HI:`RD_LO];

  assign ex_opcode = ex_q.opcode;
  assign ex_rs     = ex_q.rs;
  assign ex_rt     = ex_q.rt;
  assign ex_rd     = ex_q.rd;
  assign ex_mem_op = ex_q.mem_op;

  // program counter steps one pair at a time.
  pipe_reg #(.payload_t(pc_t)) u_pc_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (pc_hold),
    .nop      (nop[`PIPE_REG_PC]),
    .d        (pc_next),
    .valid_in (1'b1),
    .q        (pc),
    .valid    ()
  );

  pipe_reg #(.payload_t(instr_pair_t)) u_if_id_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (if_id_hold),
    .nop      (nop[`PIPE_REG_IF_ID]),
    .d        (fetch_pair),
    .valid_in (1'b1),                   // live from the first edge out of reset.
    .q        (if_id_pair),
    .valid    (if_id_valid)
  );

  slot_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .if_id_valid (if_id_valid),
    .hold        (stall[`PIPE_REG_PC]),
    .pair        (if_id_pair),
    .first       (first),
    .issue       (issue),
    .issue_valid (issue_valid),
    .pair_done   (pair_done)
  );

  hazard_detection_unit u_hdu (
    .id_ex_valid   (ex_valid),
    .id_ex_mem_op  (ex_q.mem_op),
    .id_ex_rt      (ex_q.rt),
    .first         (first),
    .if_id_valid   (if_id_valid),
    .if_id_opcode0 (if_id_opcode0),
    .if_id_opcode1 (if_id_opcode1),
    .if_id_rs0     (if_id_rs0),
    .if_id_rt0     (if_id_rt0),
    .if_id_rd0     (if_id_rd0),
    .if_id_rs1     (if_id_rs1),
    .if_id_rt1     (if_id_rt1),
    .if_id_rd1     (if_id_rd1),
    .stall         (stall),
    .nop           (nop)
  );

  pipe_reg #(.payload_t(issued_t)) u_id_ex_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall[`PIPE_REG_ID_EX]),
    .nop      (nop[`PIPE_REG_ID_EX]),
    .d        (issue),
    .valid_in (issue_valid),
    .q        (ex_q),
    .valid    (ex_valid)
  );

endmodule

// ==== design/slot_sequencer.sv ====
`timescale 1ns/1ns

`include "cpu_consts.svh"

module slot_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 if_id_valid,
  input  logic                 hold,         // hazard freeze.
  input  cpu_pkg::instr_pair_t pair,
  output logic                 first,        // slot 0 is up next.
  output cpu_pkg::issued_t     issue,
  output logic                 issue_valid,
  output logic                 pair_done
);

  import cpu_pkg::*;

  logic [`INSTR_BITS-1:0] word;
  logic                   slot_fire;
  mem_op_t                slot_mem_op;

  assign word      = first ? pair.slot0 : pair.slot1;
  assign slot_fire = if_id_valid & ~hold;

  // slot 1 leaving frees IF/ID for the next pair.
  assign pair_done   = slot_fire & ~first;
  assign issue_valid = if_id_valid;       // a held slot is bubbled in ID/EX.

  operand_decoder u_dec (
    .opcode   (word[`OPCODE_HI:`OPCODE_LO]),
    .src_mask (),
    .dst_mask (),
    .mem_op   (slot_mem_op)
  );

  always_comb begin
    issue.opcode = word[`OPCODE_HI:`OPCODE_LO];
    issue.rs     = word[`RS_HI:`RS_LO];
    issue.rt     = word[`RT_HI:`RT_LO];
    issue.rd     = word[`RD_HI:`RD_LO];
    issue.mem_op = slot_mem_op;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first <= 1'b1;
    end else if (slot_fire) begin
      first <= ~first;                    // alternate slots.
    end
  end

endmodule

// ==== design/hazard_detection_unit.sv ====
`timescale 1ns/1ns

`include "cpu_consts.svh"

module hazard_detection_unit (
  input  logic                id_ex_valid,
  input  cpu_pkg::mem_op_t    id_ex_mem_op,
  input  cpu_pkg::reg_idx_t   id_ex_rt,       // load target in ex.
  input  logic                first,
  input  logic                if_id_valid,
  input  cpu_pkg::opcode_t    if_id_opcode0,
  input  cpu_pkg::opcode_t    if_id_opcode1,
  input  cpu_pkg::reg_idx_t   if_id_rs0,
  input  cpu_pkg::reg_idx_t   if_id_rt0,
  input  cpu_pkg::reg_idx_t   if_id_rd0,
  input  cpu_pkg::reg_idx_t   if_id_rs1,
  input  cpu_pkg::reg_idx_t   if_id_rt1,
  input  cpu_pkg::reg_idx_t   if_id_rd1,
  output cpu_pkg::pipe_mask_t stall,
  output cpu_pkg::pipe_mask_t nop
);

  import cpu_pkg::*;

  reg_mask_t src_mask0;
  reg_mask_t dst_mask0;
  reg_mask_t src_mask1;
  reg_mask_t dst_mask1;

  reg_mask_t iss_src;
  reg_idx_t  iss_rs;
  reg_idx_t  iss_rt;
  reg_mask_t oth_dst;
  reg_idx_t  oth_rt;
  reg_idx_t  oth_rd;

  logic load_use;
  logic slot_conflict;

  // true when a source field of one slot names a destination of the other.
  function automatic logic reads_written(input reg_mask_t src, input reg_idx_t rs,
                                         input reg_idx_t rt, input reg_mask_t dst,
                                         input reg_idx_t wr_rt, input reg_idx_t wr_rd);
    logic hit;
    hit = 1'b0;
    if (src[`REG_MASK_RS] && dst[`REG_MASK_RT] && rs == wr_rt) hit = 1'b1;
    if (src[`REG_MASK_RS] && dst[`REG_MASK_RD] && rs == wr_rd) hit = 1'b1;
    if (src[`REG_MASK_RT] && dst[`REG_MASK_RT] && rt == wr_rt) hit = 1'b1;
    if (src[`REG_MASK_RT] && dst[`REG_MASK_RD] && rt == wr_rd) hit = 1'b1;
    return hit;
  endfunction

  operand_decoder u_dec0 (
    .opcode   (if_id_opcode0),
    .src_mask (src_mask0),
    .dst_mask (dst_mask0),
    .mem_op   ()
  );

  operand_decoder u_dec1 (
    .opcode   (if_id_opcode1),
    .src_mask (src_mask1),
    .dst_mask (dst_mask1),
    .mem_op   ()
  );

  // issuing slot against the other slot of the pair.
  assign iss_src = first ? src_mask0 : src_mask1;
  assign iss_rs  = first ? if_id_rs0 : if_id_rs1;
  assign iss_rt  = first ? if_id_rt0 : if_id_rt1;
  assign oth_dst = first ? dst_mask1 : dst_mask0;
  assign oth_rt  = first ? if_id_rt1 : if_id_rt0;
  assign oth_rd  = first ? if_id_rd1 : if_id_rd0;

  assign load_use = id_ex_valid && (id_ex_mem_op == MEM_OP_READ) &&
                    ((iss_src[`REG_MASK_RS] && iss_rs == id_ex_rt) ||
                     (iss_src[`REG_MASK_RT] && iss_rt == id_ex_rt));

  // an empty ID/EX already separates the slots, so one bubble clears it.
  assign slot_conflict = id_ex_valid &&
                         reads_written(iss_src, iss_rs, iss_rt, oth_dst, oth_rt, oth_rd);

  // both cases freeze the front end and drop a bubble into ex.
  always_comb begin
    stall = '0;
    nop   = '0;
    if (if_id_valid && (load_use || slot_conflict)) begin
      stall[`PIPE_REG_PC]    = 1'b1;
      stall[`PIPE_REG_IF_ID] = 1'b1;
      stall[`PIPE_REG_ID_EX] = 1'b1;
      nop[`PIPE_REG_ID_EX]   = 1'b1;
    end
  end

endmodule

// ==== design/operand_decoder.sv ====
`timescale 1ns/1ns

`include "cpu_consts.svh"

module operand_decoder (
  input  cpu_pkg::opcode_t   opcode,
  output cpu_pkg::reg_mask_t src_mask,
  output cpu_pkg::reg_mask_t dst_mask,
  output cpu_pkg::mem_op_t   mem_op
);

  import cpu_pkg::*;

  always_comb begin
    src_mask = '0;
    dst_mask = '0;
    mem_op   = MEM_OP_NONE;
    casez (opcode)
      `OP_CODE_NOP: begin
        src_mask = '0;                          // nothing read or written.
      end
      `OP_CODE_JR: begin
        src_mask[`REG_MASK_RS] = 1'b1;          // jump target in rs.
      end
      6'b00????: begin                          // add, sub and friends.
        src_mask[`REG_MASK_RS] = 1'b1;
        src_mask[`REG_MASK_RT] = 1'b1;
        dst_mask[`REG_MASK_RD] = 1'b1;
      end
      6'b01????: begin                          // immediate forms.
        src_mask[`REG_MASK_RS] = 1'b1;
        dst_mask[`REG_MASK_RT] = 1'b1;
      end
      `OP_CODE_LW: begin
        src_mask[`REG_MASK_RS] = 1'b1;
        dst_mask[`REG_MASK_RT] = 1'b1;
        mem_op                 = MEM_OP_READ;
      end
      `OP_CODE_SW: begin
        src_mask[`REG_MASK_RS] = 1'b1;
        src_mask[`REG_MASK_RT] = 1'b1;
        mem_op                 = MEM_OP_WRITE;
      end
      `OP_CODE_LA: begin                        // absolute load.
        dst_mask[`REG_MASK_RT] = 1'b1;
        mem_op                 = MEM_OP_READ;
      end
      `OP_CODE_SA: begin                        // absolute store.
        src_mask[`REG_MASK_RT] = 1'b1;
        mem_op                 = MEM_OP_WRITE;
      end
      default: begin
        mem_op = MEM_OP_NONE;                   // jumps and unused codes.
      end
    endcase
  end

endmodule

// ==== design/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,     // hold q and valid.
  input  logic     nop,       // bubble that wins over stall.
  input  payload_t d,
  input  logic     valid_in,
  output payload_t q,
  output logic     valid
);

  // a bubble only drops valid and leaves the old payload in q.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q     <= '0;
      valid <= 1'b0;
    end else if (nop) begin
      valid <= 1'b0;
    end else if (!stall) begin
      q     <= d;
      valid <= valid_in;
    end
  end

endmodule

// ==== design/cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`NUM_REGISTERS_LOG2-1:0] reg_idx_t;  // register number.
  typedef logic [`OP_CODE_BITS-1:0]       opcode_t;

  typedef enum logic [`MEM_OP_BITS-1:0] {
    MEM_OP_NONE  = 2'd0,
    MEM_OP_READ  = 2'd1,
    MEM_OP_WRITE = 2'd2
  } mem_op_t;

  // bit 2 rs, bit 1 rt, bit 0 rd.
  typedef logic [`REG_MASK_BITS-1:0]      reg_mask_t;

  typedef logic [`NUM_PIPE_MASKS-1:0]     pipe_mask_t;

  typedef logic [`PC_BITS-1:0]            pc_t;

  // fetched pair, slot 0 sits at pc.
  typedef struct packed {
    logic [`INSTR_BITS-1:0] slot1;
    logic [`INSTR_BITS-1:0] slot0;
  } instr_pair_t;

  // one instruction as it leaves the issue stage.
  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    mem_op_t  mem_op;
  } issued_t;

endpackage

// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths.
`define INSTR_BITS          32
`define OP_CODE_BITS        6
`define NUM_REGISTERS_LOG2  5
`define PC_BITS             32
`define MEM_OP_BITS         2
`define REG_MASK_BITS       3

// bytes fetched per pair.
`define FETCH_STEP          8

// opcode values.
`define OP_CODE_NOP         6'b000000
`define OP_CODE_JR          6'b110111
`define OP_CODE_LW          6'b100000
`define OP_CODE_SW          6'b100001
`define OP_CODE_LA          6'b100010
`define OP_CODE_SA          6'b100011

// instruction field positions.
`define OPCODE_HI           31
`define OPCODE_LO           26
`define RS_HI               25
`define RS_LO               21
`define RT_HI               20
`define RT_LO               16
`define RD_HI               15
`define RD_LO               11

// register mask bits, src and dst alike.
`define REG_MASK_RS         2
`define REG_MASK_RT         1
`define REG_MASK_RD         0

// pipe mask bit positions.
`define NUM_PIPE_MASKS      3
`define PIPE_REG_PC         0
`define PIPE_REG_IF_ID      1
`define PIPE_REG_ID_EX      2

`endif
